/* source/mult_config.svh */
`ifndef MULT_CONFIG_SVH
`define MULT_CONFIG_SVH

// operand and result widths
`define MULT_WIDTH 8
`define PROD_WIDTH 16

// widest segment used in the reduction tree
`define CLA_SEG_WIDTH 4

// covers product bits 1 to 14
`define FINAL_ADD_WIDTH 14

`endif

/* source/mult_pkg.sv */
`include "mult_config.svh"

package mult_pkg;

    typedef logic [`MULT_WIDTH-1:0] operand_t;
    typedef logic [`PROD_WIDTH-1:0] product_t; // also used for the reduced rows

    // row i holds a & b[i], weighted by 2**i
    typedef operand_t [`MULT_WIDTH-1:0] pp_matrix_t;

    typedef enum logic [1:0] {
        st_idle,
        st_reduce,
        st_add,
        st_done
    } ctrl_state_t;

endpackage

/* source/cla_segment.sv */
`timescale 1ns/100ps
`include "mult_config.svh"

module cla_segment #(
    parameter int WIDTH = `CLA_SEG_WIDTH
) (
    input  logic [WIDTH-1:0] in_a,
    input  logic [WIDTH-1:0] in_b,
    input  logic             cin,
    output logic [WIDTH-1:0] sum,
    output logic             cout
);

    logic [WIDTH-1:0] g;
    logic [WIDTH-1:0] p;
    logic [WIDTH:0]   carry;

    assign g = in_a & in_b; // generate
    assign p = in_a ^ in_b; // propagate

    // lookahead chain, carry[i] enters bit i
    always_comb begin
        carry[0] = cin;
        for (int i = 0; i < WIDTH; i++) begin
            carry[i+1] = g[i] | (p[i] & carry[i]);
        end
    end

    assign sum  = p ^ carry[WIDTH-1:0];
    assign cout = carry[WIDTH];

endmodule

/* source/partial_product_gen.sv */
`timescale 1ns/100ps
`include "mult_config.svh"

module partial_product_gen (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 ld_operands,
    input  mult_pkg::operand_t   a,
    input  mult_pkg::operand_t   b,
    output mult_pkg::pp_matrix_t pp_matrix
);

    import mult_pkg::*;

    operand_t a_q;
    operand_t b_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            a_q <= '0;
            b_q <= '0;
        end else if (ld_operands) begin
            a_q <= a;
            b_q <= b;
        end
    end

    // 64 AND terms, row per bit of b
    always_comb begin
        for (int i = 0; i < `MULT_WIDTH; i++) begin
            for (int j = 0; j < `MULT_WIDTH; j++) begin
                pp_matrix[i][j] = a_q[j] & b_q[i];
            end
        end
    end

endmodule

/* source/dadda_reduce.sv */
`timescale 1ns/100ps
`include "mult_config.svh"

module dadda_reduce (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 ld_rows,
    input  mult_pkg::pp_matrix_t pp_matrix,
    output mult_pkg::product_t   sum_row,
    output mult_pkg::product_t   carry_row
);

    import mult_pkg::*;

    pp_matrix_t pp;

    logic [`CLA_SEG_WIDTH-1:0] s1, s2, s3, s4, s5;
    logic [`CLA_SEG_WIDTH-1:0] s7, s8, s9, s10, s11;
    logic [1:0]                s6; // only short segment
    logic c1, c2, c3, c4, c5, c6, c7, c8, c9, c10, c11;

    product_t sum_d;
    product_t carry_d;

    assign pp = pp_matrix;

    // first pass, plain pairs of matrix bits
    cla_segment #(.WIDTH(`CLA_SEG_WIDTH)) u_seg1 (
        .in_a (pp[2][7:4]),
        .in_b (pp[3][6:3]),
        .cin  (1'b0),
        .sum  (s1),
        .cout (c1)
    );

    cla_segment #(.WIDTH(`CLA_SEG_WIDTH)) u_seg2 (
        .in_a (pp[4][4:1]),
        .in_b (pp[5][3:0]),
        .cin  (1'b0),
        .sum  (s2),
        .cout (c2)
    );

    cla_segment #(.WIDTH(`CLA_SEG_WIDTH)) u_seg3 (
        .in_a (pp[6][4:1]),
        .in_b (pp[7][3:0]),
        .cin  (1'b0),
        .sum  (s3),
        .cout (c3)
    );

    cla_segment #(.WIDTH(`CLA_SEG_WIDTH)) u_seg4 (
        .in_a (pp[0][6:3]),
        .in_b (pp[1][5:2]),
        .cin  (1'b0),
        .sum  (s4),
        .cout (c4)
    );

    // s3[0] rides in as the carry of column 7
    cla_segment #(.WIDTH(`CLA_SEG_WIDTH)) u_seg5 (
        .in_a ({pp[3][7], pp[4][5], pp[1][7], pp[0][7]}),
        .in_b ({pp[4][6], pp[5][4], s1[2], pp[1][6]}),
        .cin  (s3[0]),
        .sum  (s5),
        .cout (c5)
    );

    cla_segment #(.WIDTH(2)) u_seg6 (
        .in_a ({pp[5][7], pp[4][7]}),
        .in_b ({pp[6][6], pp[5][6]}),
        .cin  (c3),
        .sum  (s6),
        .cout (c6)
    );

    // second pass mixes matrix bits with earlier sums
    cla_segment #(.WIDTH(`CLA_SEG_WIDTH)) u_seg7 (
        .in_a ({s1[1], pp[6][0], pp[2][3], pp[2][2]}),
        .in_b ({s2[2], s1[0], pp[3][2], pp[3][1]}),
        .cin  (1'b0),
        .sum  (s7),
        .cout (c7)
    );

    cla_segment #(.WIDTH(`CLA_SEG_WIDTH)) u_seg8 (
        .in_a ({pp[6][5], pp[5][5], s1[3], s2[3]}),
        .in_b ({pp[7][4], c1, c2, s3[1]}),
        .cin  (1'b0),
        .sum  (s8),
        .cout (c8)
    );

    cla_segment #(.WIDTH(`CLA_SEG_WIDTH)) u_seg9 (
        .in_a ({s2[0], pp[4][0], pp[2][1], pp[0][2]}),
        .in_b ({s4[2], s4[1], pp[3][0], pp[1][1]}),
        .cin  (1'b0),
        .sum  (s9),
        .cout (c9)
    );

    cla_segment #(.WIDTH(`CLA_SEG_WIDTH)) u_seg10 (
        .in_a ({s3[2], s5[1], c4, s2[1]}),
        .in_b ({s5[2], c7, s5[0], s4[3]}),
        .cin  (s7[2]),
        .sum  (s10),
        .cout (c10)
    );

    cla_segment #(.WIDTH(`CLA_SEG_WIDTH)) u_seg11 (
        .in_a ({pp[6][7], pp[7][5], c5, s3[3]}),
        .in_b ({pp[7][6], s6[1], s6[0], s5[3]}),
        .cin  (s8[2]),
        .sum  (s11),
        .cout (c11)
    );

    // two rows left, bit 0 of carry and bit 15 of both stay empty
    assign sum_d = {1'b0, pp[7][7], c6, c8, s8[3], c10, s8[1], s8[0],
                    s7[3], c9, s7[1], s7[0], s4[0], pp[2][0], pp[0][1], pp[0][0]};
    assign carry_d = {1'b0, c11, s11, s10, s9, pp[1][0], 1'b0};

    always_ff @(posedge clk) begin
        if (rst) begin
            sum_row   <= '0;
            carry_row <= '0;
        end else if (ld_rows) begin
            sum_row   <= sum_d;
            carry_row <= carry_d;
        end
    end

endmodule

/* source/final_adder.sv */
`timescale 1ns/100ps
`include "mult_config.svh"

module final_adder (
    input  logic               clk,
    input  logic               rst,
    input  logic               ld_product,
    input  mult_pkg::product_t sum_row,
    input  mult_pkg::product_t carry_row,
    output mult_pkg::product_t product
);

    import mult_pkg::*;

    logic [`FINAL_ADD_WIDTH-1:0] add_sum;
    logic                        add_cout;
    product_t                    product_d;

    // carry_row[0] is always zero, used as the carry in
    cla_segment #(.WIDTH(`FINAL_ADD_WIDTH)) u_cla (
        .in_a (sum_row[`FINAL_ADD_WIDTH:1]),
        .in_b (carry_row[`FINAL_ADD_WIDTH:1]),
        .cin  (carry_row[0]),
        .sum  (add_sum),
        .cout (add_cout)
    );

    assign product_d = {add_cout, add_sum, sum_row[0]}; // lsb needs no add

    always_ff @(posedge clk) begin
        if (rst) begin
            product <= '0;
        end else if (ld_product) begin
            product <= product_d;
        end
    end

endmodule

/* source/mult_ctrl.sv */
`timescale 1ns/100ps

module mult_ctrl (
    input  logic clk,
    input  logic rst,
    input  logic req,
    output logic ld_operands,
    output logic ld_rows,
    output logic ld_product,
    output logic ack
);

    import mult_pkg::*;

    ctrl_state_t state;
    ctrl_state_t state_nxt;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            st_idle: begin
                if (req) begin
                    state_nxt = st_reduce;
                end
            end
            st_reduce: state_nxt = st_add;
            st_add:    state_nxt = st_done;
            st_done: begin
                // hold the result until the requester lets go
                if (!req) begin
                    state_nxt = st_idle;
                end
            end
            default: state_nxt = st_idle;
        endcase
    end

    // operands latch on the same edge that accepts req
    assign ld_operands = (state == st_idle) && req;
    assign ld_rows     = (state == st_reduce);
    assign ld_product  = (state == st_add);
    assign ack         = (state == st_done);

endmodule

/* source/mult_top.sv */
`timescale 1ns/100ps

module mult_top (
    input  logic               clk,
    input  logic               rst,
    input  logic               req,
    input  mult_pkg::operand_t a,
    input  mult_pkg::operand_t b,
    output logic               ack,
    output mult_pkg::product_t product
);

    import mult_pkg::*;

    logic       ld_operands;
    logic       ld_rows;
    logic       ld_product;
    pp_matrix_t pp_matrix;
    product_t   sum_row;
    product_t   carry_row;

    mult_ctrl u_ctrl (
        .clk         (clk),
        .rst         (rst),
        .req         (req),
        .ld_operands (ld_operands),
        .ld_rows     (ld_rows),
        .ld_product  (ld_product),
        .ack         (ack)
    );

    partial_product_gen u_ppgen (
        .clk         (clk),
        .rst         (rst),
        .ld_operands (ld_operands),
        .a           (a),
        .b           (b),
        .pp_matrix   (pp_matrix)
    );

    // matrix down to two rows
    dadda_reduce u_reduce (
        .clk       (clk),
        .rst       (rst),
        .ld_rows   (ld_rows),
        .pp_matrix (pp_matrix),
        .sum_row   (sum_row),
        .carry_row (carry_row)
    );

    final_adder u_final (
        .clk        (clk),
        .rst        (rst),
        .ld_product (ld_product),
        .sum_row    (sum_row),
        .carry_row  (carry_row),
        .product    (product)
    );

endmodule

/* test/tb_clock_gen.sv */
`timescale 1ns/100ps

module tb_clock_gen #(
    parameter int PERIOD = 40
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    // free running, half period per phase
    always begin
        #(PERIOD / 2);
        clk = ~clk;
    end

endmodule

/* test/tb_mult.sv */
`timescale 1ns/100ps
`include "mult_config.svh"

module tb_mult;

    import mult_pkg::*;

    localparam int NUM_RANDOM  = 300;
    localparam int MAX_CYCLES  = 4000; // 373 operations at roughly 10 cycles each
    localparam int ACK_LATENCY = 4;    // falling edges from the req drive edge to ack high
    localparam int WAIT_LIMIT  = 20;

    logic     clk;
    logic     rst;
    logic     req;
    operand_t a;
    operand_t b;
    logic     ack;
    product_t product;

    int cycle_count = 0;
    int seed = 32'h3cb9;

    logic [`MULT_WIDTH-1:0] corner_vals [3] = '{8'h00, 8'h01, 8'hff};

    tb_clock_gen #(.PERIOD(40)) clk_gen_i (
        .clk (clk)
    );

    mult_top dut_i (
        .clk     (clk),
        .rst     (rst),
        .req     (req),
        .a       (a),
        .b       (b),
        .ack     (ack),
        .product (product)
    );

    // global cycle limit
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("simulation ran past %0d cycles without finishing", MAX_CYCLES);
            $display("RESULT: FAIL");
            $fatal(1, "cycle limit reached");
        end
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("FAIL %s: got 0x%0h, expected 0x%0h", name, actual, expected);
            $display("RESULT: FAIL");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // one full four-phase handshake, holding req for extra cycles after ack
    task automatic run_op(input operand_t op_a, input operand_t op_b, input int extra);
        product_t expected;
        int       edges;
        expected = product_t'(op_a) * product_t'(op_b); // plain unsigned product
        edges = 0;
        @(posedge clk);
        a   <= op_a;
        b   <= op_b;
        req <= 1'b1;
        while (!ack && edges < WAIT_LIMIT) begin
            @(negedge clk);
            edges++;
        end
        if (!ack) begin
            $display("ack never rose within %0d cycles of req", WAIT_LIMIT);
            $display("RESULT: FAIL");
            $fatal(1, "handshake timeout");
        end
        check_value("ack_latency", edges, ACK_LATENCY);
        check_value("product", {16'h0, product}, {16'h0, expected});
        // back-pressure, result must hold
        for (int i = 0; i < extra; i++) begin
            @(negedge clk);
            check_value("ack", {31'h0, ack}, 32'h1);
            check_value("product", {16'h0, product}, {16'h0, expected});
        end
        @(posedge clk);
        req <= 1'b0;
        @(negedge clk);
        check_value("ack", {31'h0, ack}, 32'h1); // req low not sampled yet
        @(negedge clk);
        check_value("ack", {31'h0, ack}, 32'h0);
    endtask

    initial begin
        logic [31:0] rnd;
        operand_t    op_a;
        operand_t    op_b;
        int          extra;

        rst = 1'b1;
        req = 1'b0;
        a   = '0;
        b   = '0;

        repeat (2) @(posedge clk);
        rst <= 1'b0;

        @(negedge clk);
        check_value("ack", {31'h0, ack}, 32'h0);
        check_value("product", {16'h0, product}, 32'h0);
        // idle with req low
        repeat (5) begin
            @(negedge clk);
            check_value("ack", {31'h0, ack}, 32'h0);
        end

        // 0, 1 and 255 against each other
        for (int i = 0; i < 3; i++) begin
            for (int j = 0; j < 3; j++) begin
                run_op(corner_vals[i], corner_vals[j], 0);
            end
        end

        // every pair of powers of two
        for (int i = 0; i < `MULT_WIDTH; i++) begin
            for (int j = 0; j < `MULT_WIDTH; j++) begin
                run_op(8'h01 << i, 8'h01 << j, 0);
            end
        end

        for (int n = 0; n < NUM_RANDOM; n++) begin
            rnd   = $random(seed);
            op_a  = rnd[7:0];
            op_b  = rnd[15:8];
            extra = int'(rnd[31:16]) % 7;
            run_op(op_a, op_b, extra);
        end

        $display("RESULT: PASS");
        $finish;
    end

endmodule

/* list.f */
+incdir+source
source/mult_pkg.sv
source/cla_segment.sv
source/partial_product_gen.sv
source/dadda_reduce.sv
source/final_adder.sv
source/mult_ctrl.sv
source/mult_top.sv
test/tb_clock_gen.sv
test/tb_mult.sv

/* run.sh */
#!/bin/sh
# Build and run the multiplier testbench with Verilator.
# The exit status of the simulation binary is the result of the run.
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f list.f --top-module tb_mult -o tb_mult_sim

./obj_dir/tb_mult_sim
